// ==== common/panel_ifs.sv ====
// ==========================================================================
// Panel interfaces
// fill request between requester and fill engine, and frame byte write
// ==========================================================================
`timescale 1ns/1ps

interface fill_req_if;
    logic start;                          // one cycle pulse
    panel_types_pkg::geom_byte_t x1;
    panel_types_pkg::geom_byte_t y1;
    panel_types_pkg::geom_byte_t width;
    panel_types_pkg::geom_byte_t height;
    panel_types_pkg::color_t color;       // held with geometry until done
    logic done;                           // one cycle after last write

    modport requester (
        output start, x1, y1, width, height, color,
        input done
    );

    modport engine (
        input start, x1, y1, width, height, color,
        output done
    );
endinterface

interface fb_write_if;
    logic we;
    panel_types_pkg::row_addr_t row;
    panel_types_pkg::col_addr_t column;
    panel_types_pkg::byte_sel_t byte_sel;
    logic [7:0] data;

    modport source (
        output we, row, column, byte_sel, data
    );

    modport sink (
        input we, row, column, byte_sel, data
    );
endinterface

// ==== common/panel_params_pkg.sv ====
// ==========================================================================
// Panel params package
// fixed geometry of the LED panel and frame buffer sizing
// ==========================================================================
package panel_params_pkg;

    // panel size in pixels
    localparam int unsigned PIXEL_WIDTH = 16;   // columns
    localparam int unsigned PIXEL_HEIGHT = 8;   // rows

    // one byte per color channel, first received byte is msb
    localparam int unsigned BYTES_PER_PIXEL = 3;

    localparam int unsigned FB_BYTES = PIXEL_WIDTH * PIXEL_HEIGHT * BYTES_PER_PIXEL;

endpackage

// ==== common/panel_types_pkg.sv ====
// ==========================================================================
// Panel types package
// address, color, opcode and control state types
// ==========================================================================
package panel_types_pkg;

    typedef logic [$clog2(panel_params_pkg::PIXEL_WIDTH)-1:0] col_addr_t;
    typedef logic [$clog2(panel_params_pkg::PIXEL_HEIGHT)-1:0] row_addr_t;
    typedef logic [1:0] byte_sel_t;   // 2 = msb of the color
    typedef logic [$clog2(panel_params_pkg::FB_BYTES)-1:0] fb_addr_t;

    typedef logic [8*panel_params_pkg::BYTES_PER_PIXEL-1:0] color_t;
    typedef logic [7:0] geom_byte_t;

    typedef enum logic [7:0] {
        NOP = 8'h00,
        FILL_PANEL = 8'h01,
        FILL_AREA = 8'h02
    } cmd_op_t;

    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_PANEL,        // bytes go to the fill panel command
        CTRL_AREA_GEOM,
        CTRL_AREA_COLOR,
        CTRL_AREA_START,
        CTRL_AREA_WAIT
    } ctrl_state_t;

endpackage

// ==== design/control/command_control.sv ====
// ==========================================================================
// Command control
// decodes opcodes, captures area geometry and owns the fill engine mux
// ==========================================================================
`timescale 1ns/1ps

module command_control (
    input logic clk,
    input logic reset,
    input logic [7:0] cmd_data,
    input logic cmd_valid,
    output logic cmd_ready,
    output logic cmd_done,
    output logic [7:0] panel_data,
    output logic panel_enable,
    input logic panel_ready,
    input logic panel_done,
    fill_req_if.engine panel_fill,
    fill_req_if.requester engine_fill
);
    panel_types_pkg::ctrl_state_t state;
    logic [1:0] byte_cnt;
    logic accept;

    panel_types_pkg::geom_byte_t area_x1, area_y1, area_width, area_height;
    panel_types_pkg::color_t area_color;

    always_comb begin
        case (state)
            panel_types_pkg::CTRL_IDLE,
            panel_types_pkg::CTRL_AREA_GEOM,
            panel_types_pkg::CTRL_AREA_COLOR: cmd_ready = 1'b1;
            panel_types_pkg::CTRL_PANEL: cmd_ready = panel_ready;
            default: cmd_ready = 1'b0;   // fill running
        endcase
    end

    assign accept = cmd_valid && cmd_ready;

    assign panel_data = cmd_data;
    assign panel_enable = (state == panel_types_pkg::CTRL_PANEL) && cmd_valid && panel_ready;

    assign cmd_done = ((state == panel_types_pkg::CTRL_PANEL) && panel_done)
                   || ((state == panel_types_pkg::CTRL_AREA_WAIT) && engine_fill.done);

    // engine owner mux
    always_comb begin
        if (state == panel_types_pkg::CTRL_PANEL) begin
            engine_fill.start = panel_fill.start;
            engine_fill.x1 = panel_fill.x1;
            engine_fill.y1 = panel_fill.y1;
            engine_fill.width = panel_fill.width;
            engine_fill.height = panel_fill.height;
            engine_fill.color = panel_fill.color;
            panel_fill.done = engine_fill.done;
        end else begin
            engine_fill.start = (state == panel_types_pkg::CTRL_AREA_START);
            engine_fill.x1 = area_x1;
            engine_fill.y1 = area_y1;
            engine_fill.width = area_width;
            engine_fill.height = area_height;
            engine_fill.color = area_color;
            panel_fill.done = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= panel_types_pkg::CTRL_IDLE;
            byte_cnt <= 2'd0;
        end else begin
            case (state)
                panel_types_pkg::CTRL_IDLE: begin
                    byte_cnt <= 2'd0;
                    if (accept) begin
                        case (panel_types_pkg::cmd_op_t'(cmd_data))
                            panel_types_pkg::FILL_PANEL: state <= panel_types_pkg::CTRL_PANEL;
                            panel_types_pkg::FILL_AREA: state <= panel_types_pkg::CTRL_AREA_GEOM;
                            panel_types_pkg::NOP: state <= panel_types_pkg::CTRL_IDLE;
                            default: state <= panel_types_pkg::CTRL_IDLE;   // unknown, dropped
                        endcase
                    end
                end
                panel_types_pkg::CTRL_PANEL: begin
                    if (panel_done)
                        state <= panel_types_pkg::CTRL_IDLE;
                end
                panel_types_pkg::CTRL_AREA_GEOM: begin
                    if (accept) begin
                        byte_cnt <= byte_cnt + 2'd1;   // wraps to 0 for color
                        if (byte_cnt == 2'd3)
                            state <= panel_types_pkg::CTRL_AREA_COLOR;
                    end
                end
                panel_types_pkg::CTRL_AREA_COLOR: begin
                    if (accept) begin
                        byte_cnt <= byte_cnt + 2'd1;
                        if (byte_cnt == 2'(panel_params_pkg::BYTES_PER_PIXEL - 1))
                            state <= panel_types_pkg::CTRL_AREA_START;
                    end
                end
                panel_types_pkg::CTRL_AREA_START: state <= panel_types_pkg::CTRL_AREA_WAIT;
                panel_types_pkg::CTRL_AREA_WAIT: begin
                    if (engine_fill.done)
                        state <= panel_types_pkg::CTRL_IDLE;
                end
                default: state <= panel_types_pkg::CTRL_IDLE;
            endcase
        end
    end

    // area payload capture
    always_ff @(posedge clk) begin
        if (accept && state == panel_types_pkg::CTRL_AREA_GEOM) begin
            case (byte_cnt)
                2'd0: area_x1 <= cmd_data;
                2'd1: area_y1 <= cmd_data;
                2'd2: area_width <= cmd_data;
                default: area_height <= cmd_data;
            endcase
        end
        if (accept && state == panel_types_pkg::CTRL_AREA_COLOR)
            area_color <= {area_color[15:0], cmd_data};   // first byte ends up msb
    end

endmodule

// ==== design/fillarea/subcmd_fill_area.sv ====
// ==========================================================================
// Fill area engine
// walks a clipped rectangle and writes one frame byte per cycle
// ==========================================================================
`timescale 1ns/1ps

module subcmd_fill_area (
    input logic clk,
    input logic reset,
    fill_req_if.engine fill,
    fb_write_if.source wr
);
    typedef enum logic {
        FA_IDLE,
        FA_WRITE
    } fa_state_t;

    fa_state_t state;
    logic done_q;

    panel_types_pkg::row_addr_t row;
    panel_types_pkg::col_addr_t col;
    panel_types_pkg::byte_sel_t bsel;

    logic [8:0] x_sum, y_sum, x_end, y_end;
    logic empty;
    logic last_byte;
    panel_types_pkg::col_addr_t col_last;
    panel_types_pkg::row_addr_t row_last;

    // clip against the right and bottom edges
    always_comb begin
        x_sum = {1'b0, fill.x1} + {1'b0, fill.width};
        y_sum = {1'b0, fill.y1} + {1'b0, fill.height};
        x_end = (x_sum > 9'(panel_params_pkg::PIXEL_WIDTH)) ?
                9'(panel_params_pkg::PIXEL_WIDTH) : x_sum;
        y_end = (y_sum > 9'(panel_params_pkg::PIXEL_HEIGHT)) ?
                9'(panel_params_pkg::PIXEL_HEIGHT) : y_sum;
        empty = ({1'b0, fill.x1} >= x_end) || ({1'b0, fill.y1} >= y_end);
        col_last = panel_types_pkg::col_addr_t'(x_end - 9'd1);
        row_last = panel_types_pkg::row_addr_t'(y_end - 9'd1);
    end

    assign last_byte = (bsel == 2'd0) && (col == col_last) && (row == row_last);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FA_IDLE;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                FA_IDLE: begin
                    if (fill.start) begin
                        if (empty)
                            done_q <= 1'b1;   // nothing to write
                        else
                            state <= FA_WRITE;
                    end
                end
                FA_WRITE: begin
                    if (last_byte) begin
                        state <= FA_IDLE;
                        done_q <= 1'b1;
                    end
                end
                default: state <= FA_IDLE;
            endcase
        end
    end

    // walk order: row, column, byte_sel high to low
    always_ff @(posedge clk) begin
        if (state == FA_IDLE) begin
            row <= panel_types_pkg::row_addr_t'(fill.y1);
            col <= panel_types_pkg::col_addr_t'(fill.x1);
            bsel <= panel_types_pkg::byte_sel_t'(panel_params_pkg::BYTES_PER_PIXEL - 1);
        end else if (bsel != 2'd0) begin
            bsel <= bsel - 2'd1;
        end else begin
            bsel <= panel_types_pkg::byte_sel_t'(panel_params_pkg::BYTES_PER_PIXEL - 1);
            if (col != col_last) begin
                col <= col + 1'b1;
            end else begin
                col <= panel_types_pkg::col_addr_t'(fill.x1);
                row <= row + 1'b1;
            end
        end
    end

    assign wr.we = (state == FA_WRITE);
    assign wr.row = row;
    assign wr.column = col;
    assign wr.byte_sel = bsel;
    assign wr.data = fill.color[8*bsel +: 8];
    assign fill.done = done_q;

endmodule

// ==== design/fillpanel/cmd_fill_panel.sv ====
// ==========================================================================
// Fill panel command
// takes three color bytes and fills the whole panel via the fill engine
// ==========================================================================
`timescale 1ns/1ps

module cmd_fill_panel (
    input logic clk,
    input logic reset,
    input logic [7:0] data_in,
    input logic enable,
    output logic ready_for_data,
    output logic done,
    fill_req_if.requester fill
);
    typedef enum logic [2:0] {
        FP_CAPTURE,
        FP_START,
        FP_RUNNING,
        FP_PREDONE,
        FP_DONE
    } fp_state_t;

    fp_state_t state;
    logic [1:0] bytes_left;
    panel_types_pkg::color_t color;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FP_CAPTURE;
            bytes_left <= 2'(panel_params_pkg::BYTES_PER_PIXEL - 1);
            ready_for_data <= 1'b1;
        end else begin
            case (state)
                FP_CAPTURE: begin
                    if (enable) begin
                        if (bytes_left == 2'd0) begin
                            state <= FP_START;
                            ready_for_data <= 1'b0;   // busy until fill finishes
                        end else begin
                            bytes_left <= bytes_left - 2'd1;
                        end
                    end
                end
                FP_START: state <= FP_RUNNING;
                FP_RUNNING: begin
                    if (fill.done)
                        state <= FP_PREDONE;
                end
                FP_PREDONE: state <= FP_DONE;
                FP_DONE: begin
                    ready_for_data <= 1'b1;
                    bytes_left <= 2'(panel_params_pkg::BYTES_PER_PIXEL - 1);
                    state <= FP_CAPTURE;
                end
                default: state <= FP_CAPTURE;
            endcase
        end
    end

    // msb first
    always_ff @(posedge clk) begin
        if (state == FP_CAPTURE && enable)
            color[8*bytes_left +: 8] <= data_in;
    end

    assign fill.start = (state == FP_START);
    assign fill.x1 = '0;
    assign fill.y1 = '0;
    assign fill.width = panel_types_pkg::geom_byte_t'(panel_params_pkg::PIXEL_WIDTH);
    assign fill.height = panel_types_pkg::geom_byte_t'(panel_params_pkg::PIXEL_HEIGHT);
    assign fill.color = color;

    assign done = (state == FP_PREDONE);

endmodule

// ==== design/frame_ram.sv ====
// ==========================================================================
// Frame buffer RAM, one byte write port and one registered read port
// ==========================================================================
`timescale 1ns/1ps

module frame_ram (
    input logic clk,
    fb_write_if.sink wr,
    input panel_types_pkg::fb_addr_t rd_addr,
    output logic [7:0] rd_data
);
    logic [7:0] mem [panel_params_pkg::FB_BYTES];
    panel_types_pkg::fb_addr_t wr_addr;

    // (row * width + column) * 3 + byte_sel
    assign wr_addr = (panel_types_pkg::fb_addr_t'(wr.row)
                      * panel_types_pkg::fb_addr_t'(panel_params_pkg::PIXEL_WIDTH)
                      + panel_types_pkg::fb_addr_t'(wr.column))
                     * panel_types_pkg::fb_addr_t'(panel_params_pkg::BYTES_PER_PIXEL)
                     + panel_types_pkg::fb_addr_t'(wr.byte_sel);

    always_ff @(posedge clk) begin
        if (wr.we)
            mem[wr_addr] <= wr.data;
        rd_data <= mem[rd_addr];   // one cycle read latency
    end

endmodule

// ==== design/panel_ctrl_top.sv ====
// ==========================================================================
// LED panel command front end, byte command stream into the frame buffer
// ==========================================================================
`timescale 1ns/1ps

module panel_ctrl_top (
    input logic clk,
    input logic reset,
    input logic [7:0] cmd_data,
    input logic cmd_valid,
    output logic cmd_ready,
    output logic cmd_done,
    input panel_types_pkg::fb_addr_t rd_addr,
    output logic [7:0] rd_data
);
    logic [7:0] panel_data;
    logic panel_enable;
    logic panel_ready;
    logic panel_done;

    fill_req_if panel_fill_bus ();
    fill_req_if engine_fill_bus ();
    fb_write_if wr_bus ();

    command_control u_control (
        .clk(clk),
        .reset(reset),
        .cmd_data(cmd_data),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_done(cmd_done),
        .panel_data(panel_data),
        .panel_enable(panel_enable),
        .panel_ready(panel_ready),
        .panel_done(panel_done),
        .panel_fill(panel_fill_bus.engine),
        .engine_fill(engine_fill_bus.requester)
    );

    cmd_fill_panel u_fill_panel (
        .clk(clk),
        .reset(reset),
        .data_in(panel_data),
        .enable(panel_enable),
        .ready_for_data(panel_ready),
        .done(panel_done),
        .fill(panel_fill_bus.requester)
    );

    subcmd_fill_area u_fill_area (
        .clk(clk),
        .reset(reset),
        .fill(engine_fill_bus.engine),
        .wr(wr_bus.source)
    );

    frame_ram u_frame_ram (
        .clk(clk),
        .wr(wr_bus.sink),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and search the log for the pass line
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module panel_tb -o panel_sim \
    && ./obj_dir/panel_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== tb/panel_tb.sv ====
// ==========================================================================
// Panel controller testbench
// random command stream checked against a byte model of the frame
// ==========================================================================
`timescale 1ns/1ps

module panel_tb;
    localparam int PANEL_W = 16;
    localparam int PANEL_H = 8;
    localparam int BPP = 3;
    localparam int FRAME_BYTES = PANEL_W * PANEL_H * BPP;
    localparam int NUM_MIX = 30;
    localparam int NUM_CMDS = 11 + NUM_MIX;   // directed part plus random mix
    localparam int MAX_FILL_CYCLES = FRAME_BYTES + 16;
    localparam int CMD_CYCLES = MAX_FILL_CYCLES + 2 * FRAME_BYTES + 64;
    localparam longint WATCHDOG_NS = 2 * NUM_CMDS * CMD_CYCLES * 10;

    logic clk;
    logic reset;
    logic [7:0] cmd_data;
    logic cmd_valid;
    logic cmd_ready;
    logic cmd_done;
    panel_types_pkg::fb_addr_t rd_addr;
    logic [7:0] rd_data;

    logic [7:0] model_mem [FRAME_BYTES];
    int seed = 81341;
    int accepted_count = 0;   // bumped on posedge and read on negedge
    int done_count = 0;
    int sent_count = 0;
    int expected_done = 0;

    tb_clock clock_gen (.clk(clk));

    panel_ctrl_top uut (
        .clk(clk),
        .reset(reset),
        .cmd_data(cmd_data),
        .cmd_valid(cmd_valid),
        .cmd_ready(cmd_ready),
        .cmd_done(cmd_done),
        .rd_addr(rd_addr),
        .rd_data(rd_data)
    );

    always @(posedge clk) begin
        if (!reset) begin
            if (cmd_valid && cmd_ready)
                accepted_count <= accepted_count + 1;
            if (cmd_done)
                done_count <= done_count + 1;
        end
    end

    task abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1);
    endtask

    function automatic int random_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task check_byte(input panel_types_pkg::fb_addr_t addr, input logic [7:0] got,
                    input logic [7:0] expected);
        if (got !== expected)
            abort_run($sformatf("ERR rd_data addr %h: got %h, expected %h", addr, got, expected));
    endtask

    task check_done(input int got, input int expected);
        if (got != expected)
            abort_run($sformatf("ERR cmd_done count: got %h, expected %h", got, expected));
    endtask

    task check_accepts();
        if (accepted_count != sent_count)
            abort_run($sformatf("ERR accepted byte count: got %h, expected %h",
                                accepted_count, sent_count));
    endtask

    task send_byte(input logic [7:0] b);
        int idle;
        int waited;
        idle = random_below(4);
        repeat (idle) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
            cmd_data <= 8'($random(seed));
        end
        @(posedge clk);
        cmd_data <= b;
        cmd_valid <= 1'b1;
        waited = 0;
        @(negedge clk);
        while (!cmd_ready) begin
            waited++;
            if (waited > 4)
                abort_run("cmd_ready stayed low while a command byte was offered");
            @(negedge clk);
        end
        sent_count++;   // taken on the coming rising edge
    endtask

    // offers a byte while busy and expects none taken
    task wait_fill();
        int cycles;
        int accepted_before;
        @(posedge clk);
        cmd_data <= 8'($random(seed));
        cmd_valid <= 1'b1;
        @(negedge clk);
        accepted_before = accepted_count;
        cycles = 0;
        while (!cmd_done) begin
            if (cmd_ready)
                abort_run("cmd_ready went high while a fill was running");
            cycles++;
            if (cycles > MAX_FILL_CYCLES)
                abort_run("no cmd_done after a fill command");
            @(negedge clk);
        end
        if (cmd_ready)
            abort_run("cmd_ready was high in the cmd_done cycle");
        @(posedge clk);
        cmd_valid <= 1'b0;
        @(negedge clk);
        if (!cmd_ready)
            abort_run("cmd_ready did not return one cycle after cmd_done");
        if (accepted_count != accepted_before)
            abort_run("a byte was consumed while cmd_ready was low");
    endtask

    task check_frame();
        for (int i = 0; i < FRAME_BYTES; i++) begin
            @(posedge clk);
            rd_addr <= panel_types_pkg::fb_addr_t'(i);
            @(posedge clk);
            @(negedge clk);
            check_byte(panel_types_pkg::fb_addr_t'(i), rd_data, model_mem[i]);
        end
    endtask

    task model_area(input int x1, input int y1, input int w, input int h,
                    input logic [7:0] c0, input logic [7:0] c1, input logic [7:0] c2);
        int x_end;
        int y_end;
        int base;
        x_end = (x1 + w > PANEL_W) ? PANEL_W : x1 + w;   // clip right
        y_end = (y1 + h > PANEL_H) ? PANEL_H : y1 + h;   // clip bottom
        for (int r = y1; r < y_end; r++) begin
            for (int c = x1; c < x_end; c++) begin
                base = (r * PANEL_W + c) * BPP;
                model_mem[base + 2] = c0;   // first color byte is msb
                model_mem[base + 1] = c1;
                model_mem[base] = c2;
            end
        end
    endtask

    task run_fill(input logic whole_panel, input int x1, input int y1, input int w, input int h);
        logic [7:0] c0;
        logic [7:0] c1;
        logic [7:0] c2;
        c0 = 8'($random(seed));
        c1 = 8'($random(seed));
        c2 = 8'($random(seed));
        if (whole_panel) begin
            send_byte(8'(panel_types_pkg::FILL_PANEL));
        end else begin
            send_byte(8'(panel_types_pkg::FILL_AREA));
            send_byte(8'(x1));
            send_byte(8'(y1));
            send_byte(8'(w));
            send_byte(8'(h));
        end
        send_byte(c0);
        send_byte(c1);
        send_byte(c2);
        wait_fill();
        if (whole_panel)
            model_area(0, 0, PANEL_W, PANEL_H, c0, c1, c2);
        else
            model_area(x1, y1, w, h, c0, c1, c2);
        expected_done++;
        check_done(done_count, expected_done);
        check_accepts();
        check_frame();
    endtask

    // opcode is taken but nothing happens
    task run_dropped(input logic [7:0] op);
        send_byte(op);
        @(posedge clk);
        cmd_valid <= 1'b0;
        repeat (4) @(negedge clk);
        check_done(done_count, expected_done);
        check_accepts();
        check_frame();
    endtask

    initial begin
        #(WATCHDOG_NS);
        abort_run("watchdog expired before the command sequence finished");
    end

    initial begin
        int x1;
        int y1;
        int w;
        int h;
        int kind;
        cmd_data = 8'h00;
        cmd_valid = 1'b0;
        rd_addr = '0;
        reset = 1'b1;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        if (cmd_done || !cmd_ready)
            abort_run("cmd_ready or cmd_done has the wrong level after reset");

        run_fill(1'b1, 0, 0, 0, 0);   // defines every frame byte
        repeat (3) begin
            x1 = random_below(PANEL_W);
            y1 = random_below(PANEL_H);
            w = 1 + random_below(PANEL_W - x1);
            h = 1 + random_below(PANEL_H - y1);
            run_fill(1'b0, x1, y1, w, h);
        end
        run_fill(1'b0, 12, 5, 10, 7);   // past right and bottom edge
        run_fill(1'b0, 20, 2, 4, 3);    // starts off the panel
        run_fill(1'b0, 3, 2, 0, 4);
        run_fill(1'b0, 6, 1, 5, 0);
        run_dropped(8'(panel_types_pkg::NOP));
        run_dropped(8'hA5);
        run_fill(1'b0, 1, 1, 3, 3);

        for (int i = 0; i < NUM_MIX; i++) begin
            kind = random_below(8);
            if (kind == 0) begin
                run_dropped(8'(panel_types_pkg::NOP));
            end else if (kind == 1) begin
                run_dropped(8'(3 + random_below(253)));
            end else if (kind == 2) begin
                run_fill(1'b1, 0, 0, 0, 0);
            end else begin
                x1 = random_below(20);
                y1 = random_below(12);
                w = random_below(20);
                h = random_below(10);
                run_fill(1'b0, x1, y1, w, h);
            end
        end

        check_done(done_count, expected_done);
        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb/tb_clock.sv ====
// ==========================================================================
// Testbench clock source, 10 ns period
// ==========================================================================
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);
    initial clk = 1'b0;

    always #5 clk = ~clk;   // 100 MHz

endmodule

// ==== vlog.f ====
common/panel_params_pkg.sv
common/panel_types_pkg.sv
common/panel_ifs.sv
design/control/command_control.sv
design/fillpanel/cmd_fill_panel.sv
design/fillarea/subcmd_fill_area.sv
design/frame_ram.sv
design/panel_ctrl_top.sv
tb/tb_clock.sv
tb/panel_tb.sv
